//--- upscale_cfg_pkg.sv
package upscale_cfg_pkg;

    // Pixel format and frame limits of the upscaler.
    localparam int PIX_W     = 8;
    localparam int MAX_COLS  = 128;
    localparam int MAX_ROWS  = 255;
    localparam int ROW_SLOTS = 3;

    localparam int COL_W    = $clog2(MAX_COLS);
    localparam int WIDTH_W  = $clog2(MAX_COLS + 1);
    localparam int HEIGHT_W = $clog2(MAX_ROWS + 1);
    localparam int OCOL_W   = COL_W + 1;
    localparam int SLOT_W   = $clog2(ROW_SLOTS + 1);
    localparam int OUT_COLS = 2 * MAX_COLS;

    typedef logic [PIX_W-1:0]    pixel_t;
    typedef logic [COL_W-1:0]    col_t;
    typedef logic [WIDTH_W-1:0]  width_t;
    typedef logic [HEIGHT_W-1:0] height_t;
    typedef logic [OCOL_W-1:0]   ocol_t;
    typedef logic [SLOT_W-1:0]   slot_t;

    // Row slots are used as a ring.
    function automatic slot_t next_slot(input slot_t s);
        if (s == slot_t'(ROW_SLOTS - 1)) begin
            return '0;
        end
        return s + 1'b1;
    endfunction

endpackage

//--- upscale_ctrl_pkg.sv
package upscale_ctrl_pkg;

    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] REG_CTRL   = 4'h0;
    localparam logic [APB_AW-1:0] REG_PIXEL  = 4'h4;
    localparam logic [APB_AW-1:0] REG_STATUS = 4'h8;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_ROWS,
        EVEN_ROW,
        ODD_ROW,
        RELEASE,
        DONE
    } seq_state_t;

    // BOTTOM is an odd output row, served from the output line memory.
    typedef enum logic [1:0] {
        TOP_LEFT,
        TOP_RIGHT,
        BOTTOM
    } pix_phase_t;

endpackage

//--- apb_pixel_port.sv
`timescale 1ns/1ps

module apb_pixel_port
    import upscale_cfg_pkg::*;
    import upscale_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [APB_AW-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              row_full,
    input  slot_t             rows_held,
    input  logic              frame_done_evt,
    output logic              pix_wr,
    output pixel_t            pix_data,
    output col_t              pix_col,
    output logic              row_end,
    output logic              frame_start,
    output width_t            cfg_width,
    output height_t           cfg_height,
    output logic              busy
);

    logic    is_ctrl;
    logic    is_pixel;
    logic    is_status;
    logic    pix_stall;
    logic    in_active;
    logic    frame_done;
    height_t in_row;

    assign is_ctrl   = paddr == REG_CTRL;
    assign is_pixel  = paddr == REG_PIXEL;
    assign is_status = paddr == REG_STATUS;

    // A pixel write waits here until the row store has a free slot.
    assign pix_stall = is_pixel && pwrite && in_active && row_full;
    assign pready    = psel && penable && !pix_stall;
    assign pslverr   = pready && (!(is_ctrl || is_pixel || is_status) ||
                                  (is_pixel && pwrite && !in_active));

    assign pix_wr   = pready && pwrite && is_pixel && in_active;
    assign pix_data = pwdata[PIX_W-1:0];
    assign row_end  = pix_col == col_t'(cfg_width - 1'b1);

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL:   prdata[15:0] = {cfg_height, cfg_width};
            REG_STATUS: prdata[5:0]  = {rows_held, 2'b00, frame_done, busy};
            default:    prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cfg_width   <= '0;
            cfg_height  <= '0;
            frame_start <= 1'b0;
            in_active   <= 1'b0;
            busy        <= 1'b0;
            frame_done  <= 1'b0;
            pix_col     <= '0;
            in_row      <= '0;
        end else begin
            frame_start <= 1'b0;
            if (frame_done_evt) begin
                busy       <= 1'b0;
                frame_done <= 1'b1;
            end
            if (pready && pwrite && is_ctrl) begin
                cfg_width   <= pwdata[7:0];
                cfg_height  <= pwdata[15:8];
                frame_start <= 1'b1;
                in_active   <= 1'b1;
                busy        <= 1'b1;
                frame_done  <= 1'b0;
                pix_col     <= '0;
                in_row      <= '0;
            end else if (pix_wr) begin
                if (row_end) begin
                    pix_col <= '0;
                    in_row  <= in_row + 1'b1;
                    // The input side of the frame closes after its last row.
                    if (in_row == cfg_height - 1'b1) begin
                        in_active <= 1'b0;
                    end
                end else begin
                    pix_col <= pix_col + 1'b1;
                end
            end
        end
    end

endmodule

//--- row_store.sv
`timescale 1ns/1ps

module row_store
    import upscale_cfg_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   frame_start,
    input  logic   pix_wr,
    input  pixel_t pix_data,
    input  col_t   pix_col,
    input  logic   row_end,
    input  logic   rd_en,
    input  slot_t  rd_slot_a,
    input  slot_t  rd_slot_b,
    input  col_t   rd_col,
    input  col_t   rd_col_next,
    input  logic   row_release,
    output logic   row_full,
    output slot_t  rows_held,
    output slot_t  oldest_slot,
    output pixel_t p_a0,
    output pixel_t p_a1,
    output pixel_t p_b0,
    output pixel_t p_b1
);

    pixel_t mem [ROW_SLOTS][MAX_COLS];
    slot_t  fill_slot;
    logic   row_done;

    assign row_done = pix_wr && row_end;
    assign row_full = rows_held == slot_t'(ROW_SLOTS);

    // The slot being filled only counts as held once its last pixel is in.
    always_ff @(posedge clk) begin
        if (!rst) begin
            fill_slot   <= '0;
            oldest_slot <= '0;
            rows_held   <= '0;
        end else if (frame_start) begin
            fill_slot   <= '0;
            oldest_slot <= '0;
            rows_held   <= '0;
        end else begin
            if (row_done) begin
                fill_slot <= next_slot(fill_slot);
            end
            if (row_release) begin
                oldest_slot <= next_slot(oldest_slot);
            end
            case ({row_done, row_release})
                2'b10:   rows_held <= rows_held + 1'b1;
                2'b01:   rows_held <= rows_held - 1'b1;
                default: rows_held <= rows_held;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pix_wr) begin
            mem[fill_slot][pix_col] <= pix_data;
        end
    end

    // Four neighbours of one input pixel, returned on the next cycle.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            p_a0 <= mem[rd_slot_a][rd_col];
            p_a1 <= mem[rd_slot_a][rd_col_next];
            p_b0 <= mem[rd_slot_b][rd_col];
            p_b1 <= mem[rd_slot_b][rd_col_next];
        end
    end

endmodule

//--- upscale_sequencer.sv
`timescale 1ns/1ps

module upscale_sequencer
    import upscale_cfg_pkg::*;
    import upscale_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       frame_start,
    input  width_t     cfg_width,
    input  height_t    cfg_height,
    input  slot_t      rows_held,
    input  slot_t      oldest_slot,
    input  logic       out_ready,
    input  pixel_t     sel_pixel,
    output logic       rd_en,
    output slot_t      rd_slot_a,
    output slot_t      rd_slot_b,
    output col_t       rd_col,
    output col_t       rd_col_next,
    output logic       row_release,
    output logic       sel_en,
    output pix_phase_t phase,
    output ocol_t      ocol,
    output pixel_t     out_pixel,
    output logic       out_valid,
    output logic       out_last,
    output logic       frame_done_evt
);

    seq_state_t state;
    height_t    in_row;
    ocol_t      ocol_cnt;
    ocol_t      last_ocol;
    col_t       cur_col;
    col_t       last_col;
    logic       last_row;
    logic       rows_ready;
    logic       issue;
    logic       row_done;
    logic       issue_last;
    logic       s1_last;
    logic       out_fire;
    logic       skid_valid;
    logic       skid_last;
    pixel_t     skid_pixel;

    assign last_row   = in_row == cfg_height - 1'b1;
    assign last_ocol  = ocol_t'({cfg_width, 1'b0} - 1'b1);
    assign last_col   = col_t'(cfg_width - 1'b1);
    assign cur_col    = ocol_cnt[OCOL_W-1:1];
    assign rows_ready = last_row ? (rows_held != '0) : (rows_held >= slot_t'(2));
    assign out_fire   = out_valid && out_ready;

    // A new pixel is only started when the skid register is sure to have room for it.
    assign issue      = ((state == EVEN_ROW) || (state == ODD_ROW)) && !skid_valid &&
                        (out_ready || !out_valid);
    assign row_done   = issue && (ocol_cnt == last_ocol);
    assign issue_last = row_done && (state == ODD_ROW) && last_row;

    // On the last input row the row below is the same row.
    assign rd_en       = issue && (state == EVEN_ROW);
    assign rd_slot_a   = oldest_slot;
    assign rd_slot_b   = last_row ? oldest_slot : next_slot(oldest_slot);
    assign rd_col      = cur_col;
    assign rd_col_next = (cur_col == last_col) ? cur_col : cur_col + 1'b1;
    assign row_release = state == RELEASE;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= IDLE;
            in_row   <= '0;
            ocol_cnt <= '0;
        end else if (frame_start) begin
            state    <= WAIT_ROWS;
            in_row   <= '0;
            ocol_cnt <= '0;
        end else begin
            case (state)
                WAIT_ROWS: begin
                    if (rows_ready) begin
                        state <= EVEN_ROW;
                    end
                end
                EVEN_ROW, ODD_ROW: begin
                    if (row_done) begin
                        ocol_cnt <= '0;
                        state    <= (state == EVEN_ROW) ? ODD_ROW : RELEASE;
                    end else if (issue) begin
                        ocol_cnt <= ocol_cnt + 1'b1;
                    end
                end
                RELEASE: begin
                    if (last_row) begin
                        state <= DONE;
                    end else begin
                        in_row <= in_row + 1'b1;
                        state  <= WAIT_ROWS;
                    end
                end
                DONE: begin
                    if (out_fire && out_last) begin
                        state <= IDLE;
                    end
                end
                default: state <= state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst || frame_start) begin
            sel_en  <= 1'b0;
            s1_last <= 1'b0;
        end else begin
            sel_en  <= issue;
            s1_last <= issue_last;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            phase <= (state == ODD_ROW) ? BOTTOM : (ocol_cnt[0] ? TOP_RIGHT : TOP_LEFT);
            ocol  <= ocol_cnt;
        end
    end

    // The selected pixel goes to the output register, or to the skid register when
    // the output is held.
    always_ff @(posedge clk) begin
        if (!rst || frame_start) begin
            out_valid      <= 1'b0;
            out_last       <= 1'b0;
            skid_valid     <= 1'b0;
            skid_last      <= 1'b0;
            frame_done_evt <= 1'b0;
        end else begin
            frame_done_evt <= out_fire && out_last;
            if (out_fire || !out_valid) begin
                if (skid_valid) begin
                    out_valid  <= 1'b1;
                    out_last   <= skid_last;
                    skid_valid <= 1'b0;
                end else begin
                    out_valid <= sel_en;
                    out_last  <= s1_last;
                end
            end else if (sel_en) begin
                skid_valid <= 1'b1;
                skid_last  <= s1_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_fire || !out_valid) begin
            out_pixel <= skid_valid ? skid_pixel : sel_pixel;
        end
        if (!skid_valid && sel_en && out_valid && !out_ready) begin
            skid_pixel <= sel_pixel;
        end
    end

endmodule

//--- out_row_select.sv
`timescale 1ns/1ps

module out_row_select
    import upscale_cfg_pkg::*;
    import upscale_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sel_en,
    input  pix_phase_t phase,
    input  ocol_t      ocol,
    input  pixel_t     p_a0,
    input  pixel_t     p_a1,
    input  pixel_t     p_b0,
    input  pixel_t     p_b1,
    output pixel_t     sel_pixel
);

    // Odd output row, filled while the even row above it is produced.
    pixel_t line_mem [OUT_COLS];

    logic [PIX_W:0]   sum_h;
    logic [PIX_W:0]   sum_v;
    logic [PIX_W+1:0] sum_q;
    pixel_t           avg_h;
    pixel_t           avg_v;
    pixel_t           avg_q;
    pixel_t           bottom_val;
    logic             wr_en;

    // Rounded averages of two and of four neighbours.
    assign sum_h = p_a0 + p_a1 + 1'b1;
    assign sum_v = p_a0 + p_b0 + 1'b1;
    assign sum_q = p_a0 + p_a1 + p_b0 + p_b1 + 2'd2;
    assign avg_h = sum_h[PIX_W:1];
    assign avg_v = sum_v[PIX_W:1];
    assign avg_q = sum_q[PIX_W+1:2];

    always_comb begin
        case (phase)
            TOP_LEFT: begin
                sel_pixel  = p_a0;
                bottom_val = avg_v;
            end
            TOP_RIGHT: begin
                sel_pixel  = avg_h;
                bottom_val = avg_q;
            end
            default: begin
                sel_pixel  = line_mem[ocol];
                bottom_val = avg_v;
            end
        endcase
    end

    assign wr_en = sel_en && (phase != BOTTOM);

    // No line memory writes happen while reset is asserted.
    always_ff @(posedge clk) begin
        if (rst && wr_en) begin
            line_mem[ocol] <= bottom_val;
        end
    end

endmodule

//--- upscale_top.sv
`timescale 1ns/1ps

module upscale_top
    import upscale_cfg_pkg::*;
    import upscale_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [APB_AW-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output pixel_t            out_pixel,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              out_last
);

    logic       pix_wr;
    pixel_t     pix_data;
    col_t       pix_col;
    logic       row_end;
    logic       frame_start;
    width_t     cfg_width;
    height_t    cfg_height;
    logic       frame_done_evt;
    logic       row_full;
    slot_t      rows_held;
    slot_t      oldest_slot;
    logic       rd_en;
    slot_t      rd_slot_a;
    slot_t      rd_slot_b;
    col_t       rd_col;
    col_t       rd_col_next;
    logic       row_release;
    pixel_t     p_a0;
    pixel_t     p_a1;
    pixel_t     p_b0;
    pixel_t     p_b1;
    logic       sel_en;
    pix_phase_t phase;
    ocol_t      ocol;
    pixel_t     sel_pixel;

    apb_pixel_port apb0 (
        .clk            (clk),
        .rst            (rst),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .row_full       (row_full),
        .rows_held      (rows_held),
        .frame_done_evt (frame_done_evt),
        .pix_wr         (pix_wr),
        .pix_data       (pix_data),
        .pix_col        (pix_col),
        .row_end        (row_end),
        .frame_start    (frame_start),
        .cfg_width      (cfg_width),
        .cfg_height     (cfg_height),
        .busy           ()
    );

    row_store rows0 (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .pix_wr      (pix_wr),
        .pix_data    (pix_data),
        .pix_col     (pix_col),
        .row_end     (row_end),
        .rd_en       (rd_en),
        .rd_slot_a   (rd_slot_a),
        .rd_slot_b   (rd_slot_b),
        .rd_col      (rd_col),
        .rd_col_next (rd_col_next),
        .row_release (row_release),
        .row_full    (row_full),
        .rows_held   (rows_held),
        .oldest_slot (oldest_slot),
        .p_a0        (p_a0),
        .p_a1        (p_a1),
        .p_b0        (p_b0),
        .p_b1        (p_b1)
    );

    upscale_sequencer seq0 (
        .clk            (clk),
        .rst            (rst),
        .frame_start    (frame_start),
        .cfg_width      (cfg_width),
        .cfg_height     (cfg_height),
        .rows_held      (rows_held),
        .oldest_slot    (oldest_slot),
        .out_ready      (out_ready),
        .sel_pixel      (sel_pixel),
        .rd_en          (rd_en),
        .rd_slot_a      (rd_slot_a),
        .rd_slot_b      (rd_slot_b),
        .rd_col         (rd_col),
        .rd_col_next    (rd_col_next),
        .row_release    (row_release),
        .sel_en         (sel_en),
        .phase          (phase),
        .ocol           (ocol),
        .out_pixel      (out_pixel),
        .out_valid      (out_valid),
        .out_last       (out_last),
        .frame_done_evt (frame_done_evt)
    );

    out_row_select sel0 (
        .clk       (clk),
        .rst       (rst),
        .sel_en    (sel_en),
        .phase     (phase),
        .ocol      (ocol),
        .p_a0      (p_a0),
        .p_a1      (p_a1),
        .p_b0      (p_b0),
        .p_b1      (p_b1),
        .sel_pixel (sel_pixel)
    );

endmodule

//--- tb_upscale.sv
`timescale 1ns/1ps

module tb_upscale
    import upscale_cfg_pkg::*;
    import upscale_ctrl_pkg::*;
();

    localparam int VEC_DEPTH   = 512;
    localparam int MAX_FRAMES  = 8;
    localparam int APB_TIMEOUT = 2000;
    localparam int OUT_TIMEOUT = 2000;

    logic              clk;
    logic              rst;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    pixel_t            out_pixel;
    logic              out_valid;
    logic              out_ready;
    logic              out_last;

    logic [7:0]  vec_mem [VEC_DEPTH];
    int          frame_base [MAX_FRAMES];
    int          n_frames;
    int          err_value;
    int          err_other;
    logic        random_ready;
    logic [31:0] lfsr;
    logic        hold_seen;
    pixel_t      held_pixel;

    upscale_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .out_pixel (out_pixel),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    always @(posedge clk) begin
        if (random_ready) begin
            lfsr      <= lfsr_step(lfsr);
            out_ready <= lfsr[31];
        end else begin
            out_ready <= 1'b1;
        end
    end

    // A held output must keep its value until it is taken.
    always @(posedge clk) begin
        if (rst && hold_seen) begin
            if (out_valid !== 1'b1) begin
                $display("out_valid dropped before the held pixel was taken");
                err_other++;
            end else if (out_pixel !== held_pixel) begin
                $display("error out_pixel held: got %h, expected %h", out_pixel, held_pixel);
                err_value++;
            end
        end
        hold_seen  <= out_valid && !out_ready;
        held_pixel <= out_pixel;
    end

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             output logic err);
        int waited;
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (!pready && waited < APB_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (pready) begin
            err = pslverr;
        end else begin
            err = 1'bx;
            $display("timeout: APB write to %h never completed", addr);
            err_other++;
        end
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err);
        int waited;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (!pready && waited < APB_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (pready) begin
            err  = pslverr;
            data = prdata;
        end else begin
            err  = 1'bx;
            data = 'x;
            $display("timeout: APB read of %h never completed", addr);
            err_other++;
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_expect(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                                input logic exp_err);
        logic err;
        apb_write(addr, data, err);
        if (err !== exp_err) begin
            $display("error pslverr on write to %h: got %h, expected %h", addr, err, exp_err);
            err_value++;
        end
    endtask

    task automatic read_expect(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] exp,
                               input string name);
        logic [APB_DW-1:0] data;
        logic              err;
        apb_read(addr, data, err);
        if (err !== 1'b0) begin
            $display("error pslverr on %s read: got %h, expected 0", name, err);
            err_value++;
        end
        if (data !== exp) begin
            $display("error %s: got %h, expected %h", name, data, exp);
            err_value++;
        end
    endtask

    task automatic load_vectors();
        int idx;
        $readmemh("upscale_vectors.txt", vec_mem);
        idx = 0;
        while (idx + 1 < VEC_DEPTH && n_frames < MAX_FRAMES &&
               !$isunknown(vec_mem[idx]) && vec_mem[idx] != 8'h00) begin
            frame_base[n_frames] = idx;
            n_frames++;
            idx = idx + 2 + 5 * vec_mem[idx] * vec_mem[idx + 1];
        end
    endtask

    task automatic push_pixels(input int base, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            write_expect(REG_PIXEL, {24'h0, vec_mem[base + i]}, 1'b0);
        end
    endtask

    task automatic collect_output(input int exp_base, input int count);
        int     n;
        int     waited;
        pixel_t exp;
        for (n = 0; n < count; n++) begin
            waited = 0;
            @(posedge clk);
            while (!(out_valid && out_ready) && waited < OUT_TIMEOUT) begin
                waited++;
                @(posedge clk);
            end
            if (!(out_valid && out_ready)) begin
                $display("timeout: output pixel %0d of %0d never arrived", n, count);
                err_other++;
                return;
            end
            exp = vec_mem[exp_base + n];
            if (out_pixel !== exp) begin
                $display("error out_pixel %0d: got %h, expected %h", n, out_pixel, exp);
                err_value++;
            end
            if (out_last !== (n == count - 1)) begin
                $display("error out_last %0d: got %h, expected %h", n, out_last,
                         n == count - 1);
                err_value++;
            end
        end
    endtask

    task automatic run_frame(input int f, input logic rand_ready);
        int                base;
        int                w;
        int                h;
        logic [APB_DW-1:0] size;
        base = frame_base[f];
        w    = vec_mem[base];
        h    = vec_mem[base + 1];
        size = {16'h0, vec_mem[base + 1], vec_mem[base]};
        random_ready <= rand_ready;
        write_expect(REG_CTRL, size, 1'b0);
        read_expect(REG_CTRL, size, "REG_CTRL");
        // A new frame is busy and holds no rows until pixels arrive.
        read_expect(REG_STATUS, 32'h1, "REG_STATUS");
        fork
            push_pixels(base + 2, w * h);
            collect_output(base + 2 + w * h, 4 * w * h);
        join
        read_expect(REG_STATUS, 32'h2, "REG_STATUS");
    endtask

    initial begin
        logic [APB_DW-1:0] data;
        logic              err;
        rst          = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        out_ready    = 1'b0;
        random_ready = 1'b0;
        lfsr         = 32'hd7a8;
        hold_seen    = 1'b0;
        held_pixel   = '0;
        err_value    = 0;
        err_other    = 0;
        n_frames     = 0;
        load_vectors();
        repeat (8) @(posedge clk);
        rst <= 1'b1;

        write_expect(4'hc, 32'h0000_1234, 1'b1);
        apb_read(4'hc, data, err);
        if (err !== 1'b1) begin
            $display("error pslverr on read of c: got %h, expected 1", err);
            err_value++;
        end
        write_expect(REG_PIXEL, 32'h55, 1'b1);
        read_expect(REG_STATUS, 32'h0, "REG_STATUS");

        if (n_frames < 3) begin
            $display("vector file holds %0d frames where 3 are needed", n_frames);
            err_other++;
        end else begin
            run_frame(0, 1'b0);
            // Same frame again, now with the output throttled.
            run_frame(0, 1'b1);
            run_frame(1, 1'b0);
            write_expect(REG_PIXEL, 32'haa, 1'b1);
            run_frame(2, 1'b1);
        end

        $display("tb_upscale finished: %0d value errors, %0d other failures",
                 err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- upscale_vectors.txt
// Per frame: width height, then width*height input pixels, then the 4*width*height
// expected output pixels in raster order. A width of 00 ends the list.
04 03
10 20 35 ff
40 41 00 80
07 08 fe 01
10 18 20 2b 35 9a ff ff
28 2c 31 26 1b 6d c0 c0
40 41 41 21 00 40 80 80
24 24 25 52 7f 60 41 41
07 08 08 83 fe 80 01 01
07 08 08 83 fe 80 01 01
01 01
9b
9b 9b 9b 9b
02 05
01 02 03 05 f0 0f 80 81 33 cc
01 02 02 02 02 03 04 04
03 04 05 05 7a 42 0a 0a
f0 80 0f 0f b8 80 48 48
80 81 81 81 5a 80 a7 a7
33 80 cc cc 33 80 cc cc
00 00

//--- upscale.f
upscale_cfg_pkg.sv
upscale_ctrl_pkg.sv
apb_pixel_port.sv
row_store.sv
upscale_sequencer.sv
out_row_select.sv
upscale_top.sv
tb_upscale.sv

//--- Bender.yml
package:
  name: upscale

sources:
  - upscale_cfg_pkg.sv
  - upscale_ctrl_pkg.sv
  - apb_pixel_port.sv
  - row_store.sv
  - upscale_sequencer.sv
  - out_row_select.sv
  - upscale_top.sv
  - target: test
    files:
      - tb_upscale.sv
